//--- vlog.f
common/conv_pkg.sv
common/conv_ctrl_if.sv
source/word_packer.sv
source/conv_ctrl.sv
systolic_array/skew_fifo.sv
systolic_array/systolic_array.sv
source/ofmap_serializer.sv
source/conv_top.sv
bench/clk_gen.sv
bench/tb_conv.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_conv
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

# exit status comes from grep, so a missing pass line fails the target
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tb_conv.sv
`timescale 1ns/1ns

module tb_conv;

  localparam int H = conv_pkg::ARRAY_HEIGHT;
  localparam int W = conv_pkg::ARRAY_WIDTH;
  localparam int DRAIN_TIMEOUT = 200;
  localparam int RESET_TIMEOUT = 20;

  logic                              clk;
  logic                              rst_n;
  logic [conv_pkg::IFMAP_WIDTH-1:0]  ifmap_dat;
  logic                              ifmap_vld;
  logic [conv_pkg::WEIGHT_WIDTH-1:0] weights_dat;
  logic                              weights_vld;
  logic [conv_pkg::OFMAP_WIDTH-1:0]  ofmap_dat;
  logic                              ofmap_vld;

  logic [15:0]       lfsr;
  conv_pkg::weight_t wm [H][W];      // weights the DUT holds
  conv_pkg::weight_t wm_next [H][W]; // next matrix to load
  conv_pkg::ofmap_t  exp_q [$];
  int recv_cnt = 0;
  int value_errs = 0;
  int count_errs = 0;
  int other_errs = 0;

  clk_gen i_clk (.clk(clk), .rst_n(rst_n));

  conv_top i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .ifmap_dat   (ifmap_dat),
    .ifmap_vld   (ifmap_vld),
    .weights_dat (weights_dat),
    .weights_vld (weights_vld),
    .ofmap_dat   (ofmap_dat),
    .ofmap_vld   (ofmap_vld)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [15:0] rand_word();
    logic [15:0] w;
    w = '0;
    for (int i = 0; i < 16; i++) begin
      w = {w[14:0], lfsr_bit()};
    end
    return w;
  endfunction

  function automatic conv_pkg::ifmap_vec_t rand_vec();
    conv_pkg::ifmap_vec_t v;
    for (int r = 0; r < H; r++) begin
      v[r] = rand_word();
    end
    return v;
  endfunction

  function automatic conv_pkg::ifmap_vec_t alt_vec(input conv_pkg::ifmap_t even,
                                                   input conv_pkg::ifmap_t odd);
    conv_pkg::ifmap_vec_t v;
    for (int r = 0; r < H; r++) begin
      v[r] = (r % 2 == 0) ? even : odd;
    end
    return v;
  endfunction

  // column c result wrapped to 32 bits
  function automatic conv_pkg::ofmap_t model_sum(input conv_pkg::ifmap_vec_t x, input int c);
    longint           acc;
    conv_pkg::ifmap_t xv;
    acc = 0;
    for (int r = 0; r < H; r++) begin
      xv = x[r];
      acc += longint'(xv) * longint'(wm[r][c]);
    end
    return conv_pkg::ofmap_t'(acc);
  endfunction

  task automatic check_ofmap(input conv_pkg::ofmap_t got, input conv_pkg::ofmap_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("error: ofmap_dat got 0x%08h expected 0x%08h", got, exp);
    end
  endtask

  task automatic check_vld(input logic got, input logic exp);
    if (got !== exp) begin
      value_errs++;
      $display("error: ofmap_vld got 0x%0h expected 0x%0h", got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp);
    if (got != exp) begin
      count_errs++;
      $display("error: ofmap word count got 0x%0h expected 0x%0h", got, exp);
    end
  endtask

  task automatic drive(input logic iv, input logic [15:0] id, input logic wv,
                       input logic [15:0] wd);
    @(negedge clk);
    ifmap_vld   = iv;
    ifmap_dat   = id;
    weights_vld = wv;
    weights_dat = wd;
  endtask

  task automatic idle(input int n);
    repeat (n) drive(1'b0, '0, 1'b0, '0);
  endtask

  task automatic fill_weights(input logic use_rand, input conv_pkg::weight_t v);
    for (int r = 0; r < H; r++) begin
      for (int c = 0; c < W; c++) begin
        wm_next[r][c] = use_rand ? conv_pkg::weight_t'(rand_word()) : v;
      end
    end
  endtask

  // ifmap words with index in [if_lo, if_hi) go in alongside the weights
  task automatic load_weights(input int if_lo, input int if_hi);
    int          k;
    logic        use_if;
    logic [15:0] junk;
    k = 0;
    for (int r = 0; r < H; r++) begin
      for (int c = 0; c < W; c++) begin
        use_if = (k >= if_lo) && (k < if_hi);
        junk   = use_if ? rand_word() : 16'h0;
        drive(use_if, junk, 1'b1, wm_next[r][c]);
        k++;
      end
    end
    idle(1);
    wm = wm_next;
  endtask

  task automatic send_vector(input conv_pkg::ifmap_vec_t x);
    for (int r = 0; r < H; r++) begin
      drive(1'b1, x[r], 1'b0, '0);
    end
    for (int c = 0; c < W; c++) begin
      exp_q.push_back(model_sum(x, c));
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < DRAIN_TIMEOUT) begin
      idle(1);
      n++;
    end
    if (exp_q.size() != 0) begin
      other_errs++;
      $display("timeout: %0d result words never came out", exp_q.size());
      exp_q.delete();
    end
    idle(W + conv_pkg::RESULT_DELAY + 4); // stray words would show up here
  endtask

  always @(negedge clk) begin
    if (rst_n && ofmap_vld) begin
      recv_cnt++;
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("output word 0x%08h came out with no result pending", ofmap_dat);
      end else begin
        check_ofmap(ofmap_dat, exp_q.pop_front());
      end
    end
  end

  initial begin
    int n;
    int base;
    ifmap_dat   = '0;
    ifmap_vld   = 1'b0;
    weights_dat = '0;
    weights_vld = 1'b0;
    lfsr        = 16'd53;

    n = 0;
    while (rst_n !== 1'b1 && n < RESET_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      other_errs++;
      $display("timeout: reset was never released");
    end
    check_vld(ofmap_vld, 1'b0);
    idle(4);

    // weights alone must not produce output
    base = recv_cnt;
    fill_weights(1'b1, '0);
    load_weights(0, 0);
    idle(12);
    check_count(recv_cnt - base, 0);

    base = recv_cnt;
    send_vector(rand_vec());
    wait_drain();
    check_count(recv_cnt - base, W);

    // several vectors in flight
    base = recv_cnt;
    for (int i = 0; i < 8; i++) begin
      send_vector(rand_vec());
    end
    wait_drain();
    check_count(recv_cnt - base, 8 * W);

    // ifmap groups sent during reload rows 1 and 2 get dropped
    base = recv_cnt;
    fill_weights(1'b1, '0);
    load_weights(W, 3 * W);
    idle(12);
    check_count(recv_cnt - base, 0);
    base = recv_cnt;
    for (int i = 0; i < 5; i++) begin
      send_vector(rand_vec());
    end
    wait_drain();
    check_count(recv_cnt - base, 5 * W);

    // extreme operands make the sums wrap
    base = recv_cnt;
    for (int m = 0; m < 2; m++) begin
      fill_weights(1'b0, (m == 0) ? 16'sh8000 : 16'sh7fff);
      load_weights(0, 0);
      send_vector(alt_vec(16'sh8000, 16'sh8000));
      send_vector(alt_vec(16'sh7fff, 16'sh7fff));
      send_vector(alt_vec(16'sh8000, 16'sh7fff));
      wait_drain();
    end
    check_count(recv_cnt - base, 6 * W);

    $display("errors: %0d value, %0d count, %0d other", value_errs, count_errs, other_errs);
    if (value_errs + count_errs + other_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- bench/clk_gen.sv
`timescale 1ns/1ns

module clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk; // 100 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

//--- source/conv_top.sv
`timescale 1ns/1ns

module conv_top (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [conv_pkg::IFMAP_WIDTH-1:0]  ifmap_dat,
  input  logic                              ifmap_vld,
  input  logic [conv_pkg::WEIGHT_WIDTH-1:0] weights_dat,
  input  logic                              weights_vld,
  output logic [conv_pkg::OFMAP_WIDTH-1:0]  ofmap_dat,
  output logic                              ofmap_vld
);

  conv_pkg::ifmap_vec_t  ifmap_vec;
  conv_pkg::weight_row_t weight_row;
  conv_pkg::ofmap_vec_t  col_sums;
  logic                  ifmap_done;
  logic                  weight_done;

  conv_ctrl_if ctl_if ();

  word_packer #(.GROUP_SIZE(conv_pkg::ARRAY_HEIGHT)) i_ifmap_packer (
    .clk        (clk),
    .rst_n      (rst_n),
    .word       (ifmap_dat),
    .word_vld   (ifmap_vld),
    .group      (ifmap_vec),
    .group_done (ifmap_done)
  );

  word_packer #(.GROUP_SIZE(conv_pkg::ARRAY_WIDTH)) i_weight_packer (
    .clk        (clk),
    .rst_n      (rst_n),
    .word       (weights_dat),
    .word_vld   (weights_vld),
    .group      (weight_row),
    .group_done (weight_done)
  );

  conv_ctrl i_ctrl (
    .clk               (clk),
    .rst_n             (rst_n),
    .ifmap_group_done  (ifmap_done),
    .weight_group_done (weight_done),
    .ctl               (ctl_if.ctrl)
  );

  systolic_array i_array (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctl           (ctl_if.array),
    .weight_row_in (weight_row),
    .ifmap_vec     (ifmap_vec),
    .col_sums      (col_sums)
  );

  ofmap_serializer i_ser (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctl       (ctl_if.serializer),
    .col_sums  (col_sums),
    .ofmap_dat (ofmap_dat),
    .ofmap_vld (ofmap_vld)
  );

endmodule

//--- source/ofmap_serializer.sv
`timescale 1ns/1ns

module ofmap_serializer (
  input  logic                 clk,
  input  logic                 rst_n,
  conv_ctrl_if.serializer      ctl,
  input  conv_pkg::ofmap_vec_t col_sums,
  output conv_pkg::ofmap_t     ofmap_dat,
  output logic                 ofmap_vld
);

  logic               active;
  conv_pkg::col_idx_t col;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active    <= 1'b0;
      col       <= '0;
      ofmap_vld <= 1'b0;
    end else begin
      ofmap_vld <= active;
      if (ctl.drain_start) begin
        // a new burst may follow the last column directly
        active <= 1'b1;
        col    <= '0;
      end else if (active) begin
        if (col == conv_pkg::col_idx_t'(conv_pkg::ARRAY_WIDTH - 1)) begin
          active <= 1'b0;
        end
        col <= col + 1'b1;
      end
    end
  end

  // column c sum is at the bottom on this cycle
  always_ff @(posedge clk) begin
    if (active) begin
      ofmap_dat <= col_sums[col];
    end
  end

endmodule

//--- systolic_array/systolic_array.sv
`timescale 1ns/1ns

module systolic_array (
  input  logic                  clk,
  input  logic                  rst_n,
  conv_ctrl_if.array            ctl,
  input  conv_pkg::weight_row_t weight_row_in,
  input  conv_pkg::ifmap_vec_t  ifmap_vec,
  output conv_pkg::ofmap_vec_t  col_sums
);

  localparam int H = conv_pkg::ARRAY_HEIGHT;
  localparam int W = conv_pkg::ARRAY_WIDTH;

  conv_pkg::ifmap_vec_t skewed;
  conv_pkg::ifmap_t     ifmap_out [H][W]; // moving right
  conv_pkg::ofmap_t     psum_out  [H][W]; // moving down

  skew_fifo i_skew (
    .clk    (clk),
    .rst_n  (rst_n),
    .vec_in (ifmap_vec),
    .load   (ctl.vec_load),
    .lanes  (skewed)
  );

  for (genvar r = 0; r < H; r++) begin : g_row
    for (genvar c = 0; c < W; c++) begin : g_col
      conv_pkg::ifmap_t  a_in;
      conv_pkg::ofmap_t  p_in;
      conv_pkg::ofmap_t  prod;
      conv_pkg::weight_t w_q;   // stationary weight
      conv_pkg::ifmap_t  a_q;
      conv_pkg::ofmap_t  p_q;

      if (c == 0) begin : g_left
        assign a_in = skewed[r];
      end else begin : g_inner
        assign a_in = ifmap_out[r][c-1];
      end

      if (r == 0) begin : g_top
        assign p_in = '0;
      end else begin : g_below
        assign p_in = psum_out[r-1][c];
      end

      assign prod = a_in * w_q; // 32-bit signed product

      always_ff @(posedge clk) begin
        if (ctl.weight_we && ctl.weight_row == conv_pkg::row_idx_t'(r)) begin
          w_q <= weight_row_in[c];
        end
      end

      always_ff @(posedge clk) begin
        a_q <= a_in;
        p_q <= p_in + prod; // wraps at 32 bits
      end

      assign ifmap_out[r][c] = a_q;
      assign psum_out[r][c]  = p_q;
    end
  end

  for (genvar c = 0; c < W; c++) begin : g_bottom
    assign col_sums[c] = psum_out[H-1][c];
  end

endmodule

//--- systolic_array/skew_fifo.sv
`timescale 1ns/1ns

module skew_fifo (
  input  logic                 clk,
  input  logic                 rst_n,
  input  conv_pkg::ifmap_vec_t vec_in,
  input  logic                 load,
  output conv_pkg::ifmap_vec_t lanes
);

  // lane r sits r stages behind lane 0
  for (genvar r = 0; r < conv_pkg::ARRAY_HEIGHT; r++) begin : g_lane
    conv_pkg::ifmap_t pipe [r+1];

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        for (int k = 0; k <= r; k++) begin
          pipe[k] <= '0;
        end
      end else begin
        // zero when idle so no stale operand reaches the MACs
        pipe[0] <= load ? vec_in[r] : '0;
        for (int k = 1; k <= r; k++) begin
          pipe[k] <= pipe[k-1];
        end
      end
    end

    assign lanes[r] = pipe[r];
  end

endmodule

//--- source/conv_ctrl.sv
`timescale 1ns/1ns

module conv_ctrl (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          ifmap_group_done,
  input  logic          weight_group_done,
  conv_ctrl_if.ctrl     ctl
);

  conv_pkg::conv_state_e               state;
  conv_pkg::row_idx_t                  row_cnt;
  logic [conv_pkg::RESULT_DELAY-1:0]   load_dly; // one bit per vector in flight

  // weight rows go straight into the grid
  assign ctl.weight_we  = weight_group_done;
  assign ctl.weight_row = row_cnt;

  // ifmap groups only count once all weights are in
  assign ctl.vec_load    = ifmap_group_done && (state == conv_pkg::STREAM);
  assign ctl.drain_start = load_dly[conv_pkg::RESULT_DELAY-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= conv_pkg::LOAD_WEIGHTS;
      row_cnt <= '0;
    end else if (weight_group_done) begin
      // a row arriving in STREAM restarts the load at row 0
      if (row_cnt == conv_pkg::row_idx_t'(conv_pkg::ARRAY_HEIGHT - 1)) begin
        state   <= conv_pkg::STREAM;
        row_cnt <= '0;
      end else begin
        state   <= conv_pkg::LOAD_WEIGHTS;
        row_cnt <= row_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_dly <= '0;
    end else begin
      load_dly <= {load_dly[conv_pkg::RESULT_DELAY-2:0], ctl.vec_load};
    end
  end

endmodule

//--- source/word_packer.sv
`timescale 1ns/1ns

module word_packer #(
  parameter int GROUP_SIZE = 4
) (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic [conv_pkg::IFMAP_WIDTH-1:0]                word,
  input  logic                                            word_vld,
  output logic [GROUP_SIZE-1:0][conv_pkg::IFMAP_WIDTH-1:0] group,
  output logic                                            group_done
);

  logic [$clog2(GROUP_SIZE)-1:0] cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt        <= '0;
      group_done <= 1'b0;
    end else begin
      group_done <= 1'b0;
      if (word_vld) begin
        if (cnt == $bits(cnt)'(GROUP_SIZE - 1)) begin
          cnt        <= '0;
          group_done <= 1'b1; // whole group visible next cycle
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  // first word of a group lands in slot 0
  always_ff @(posedge clk) begin
    if (word_vld) begin
      group[cnt] <= word;
    end
  end

endmodule

//--- common/conv_ctrl_if.sv
`timescale 1ns/1ns

interface conv_ctrl_if;

  logic                weight_we;   // write weight_row into the PE grid
  logic                vec_load;    // ifmap vector enters skew stage
  logic                drain_start; // bottom sums of column 0 ready next
  conv_pkg::row_idx_t  weight_row;

  modport ctrl (
    output weight_we,
    output weight_row,
    output vec_load,
    output drain_start
  );

  modport array (
    input weight_we,
    input weight_row,
    input vec_load
  );

  modport serializer (
    input drain_start
  );

endinterface

//--- common/conv_pkg.sv
package conv_pkg;

  localparam int ARRAY_HEIGHT = 4;  // ifmap lanes, PE rows
  localparam int ARRAY_WIDTH  = 4;  // output columns
  localparam int IFMAP_WIDTH  = 16;
  localparam int WEIGHT_WIDTH = 16;
  localparam int OFMAP_WIDTH  = 32;

  // vec_load to first column sum at the array bottom
  localparam int RESULT_DELAY = ARRAY_HEIGHT;

  typedef logic signed [IFMAP_WIDTH-1:0]  ifmap_t;
  typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;
  typedef logic signed [OFMAP_WIDTH-1:0]  ofmap_t;

  typedef ifmap_t  [ARRAY_HEIGHT-1:0] ifmap_vec_t;
  typedef weight_t [ARRAY_WIDTH-1:0]  weight_row_t;
  typedef ofmap_t  [ARRAY_WIDTH-1:0]  ofmap_vec_t;

  typedef logic [$clog2(ARRAY_HEIGHT)-1:0] row_idx_t;
  typedef logic [$clog2(ARRAY_WIDTH)-1:0]  col_idx_t;

  typedef enum logic {
    LOAD_WEIGHTS,
    STREAM
  } conv_state_e;

endpackage
